/* verilog/csr_index_settings.svh */
// --------------------------------------
// CSR index engine settings
// Widths, field codes and FIFO sizes
// --------------------------------------
`ifndef CSR_INDEX_SETTINGS_SVH
`define CSR_INDEX_SETTINGS_SVH

`define CSR_INDEX_W 32
`define CSR_ADDR_W 64
`define CSR_FIELD_W 3
`define CSR_TAG_W 8
`define CSR_GRAN_W 5

// Configuration word field codes
`define CSR_FIELD_DIR 3'd0
`define CSR_FIELD_START 3'd1
`define CSR_FIELD_END 3'd2
`define CSR_FIELD_BASE 3'd3
`define CSR_FIELD_GRAN 3'd4

`define REQ_FIFO_DEPTH 16
`define RSP_FIFO_DEPTH 16
`define FIFO_PROG_THRESH 8

`endif

/* verilog/csr_index_pkg.sv */
// --------------------------------------
// CSR index engine types
// Packets, configuration, descriptor
// and control FSM states
// --------------------------------------
`default_nettype none

`include "csr_index_settings.svh"

package csr_index_pkg;

    typedef struct packed {
        logic                  valid;
        logic [`CSR_TAG_W-1:0] tag;
    } descriptor_t;

    // One configuration word per packet
    typedef struct packed {
        logic                    valid;
        logic [`CSR_FIELD_W-1:0] field;
        logic [`CSR_ADDR_W-1:0]  value;
    } rsp_packet_t;

    typedef struct packed {
        logic                    valid;
        logic [`CSR_TAG_W-1:0]   tag;
        logic [`CSR_INDEX_W-1:0] index;
        logic [`CSR_ADDR_W-1:0]  address;
    } req_packet_t;

    // Direction 1 counts up
    typedef struct packed {
        logic                    direction;
        logic [`CSR_INDEX_W-1:0] first_index;
        logic [`CSR_INDEX_W-1:0] last_index;
        logic [`CSR_ADDR_W-1:0]  base_address;
        logic [`CSR_GRAN_W-1:0]  gran_shift;
    } csr_index_cfg_t;

    typedef enum logic [2:0] {
        CSR_INDEX_RESET = 3'd0,
        CSR_INDEX_IDLE  = 3'd1,
        CSR_INDEX_START = 3'd2,
        CSR_INDEX_BUSY  = 3'd3,
        CSR_INDEX_PAUSE = 3'd4,
        CSR_INDEX_DONE  = 3'd5
    } csr_index_state_t;

endpackage : csr_index_pkg

`default_nettype wire

/* verilog/packet_fifo.sv */
// --------------------------------------
// Packet FIFO
// Register array with first-word-fall-through
// output and a programmable-full level
// --------------------------------------
`default_nettype none

module packet_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_engine_csr_index,
    input  logic [WIDTH-1:0] din,
    input  logic             push,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             rd_en;

    // Overflow and underflow are dropped here
    assign wr_en     = push & ~full;
    assign rd_en     = pop & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == CW'(DEPTH));
    assign prog_full = (count >= CW'(PROG_THRESH));
    assign dout      = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------------------------
    // Pointers and occupancy
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : packet_fifo

`default_nettype wire

/* verilog/csr_index_config.sv */
// --------------------------------------
// CSR index configuration register
// Collects field words into one held
// configuration for the control FSM
// --------------------------------------
`default_nettype none

`include "csr_index_settings.svh"

module csr_index_config (
    input  logic                        ap_clk,
    input  logic                        areset_engine_csr_index,
    input  csr_index_pkg::rsp_packet_t  rsp,
    output logic                        cfg_ready,
    input  logic                        cfg_take,
    output csr_index_pkg::csr_index_cfg_t cfg,
    output logic                        cfg_valid
);

    logic gran_write;

    // Hold off new words until the finished configuration is taken
    assign cfg_ready  = ~cfg_valid;
    assign gran_write = rsp.valid & (rsp.field == `CSR_FIELD_GRAN);

    // --------------------------------------
    // Field decode
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rsp.valid) begin
            case (rsp.field)
                `CSR_FIELD_DIR:   cfg.direction    <= rsp.value[0];
                `CSR_FIELD_START: cfg.first_index  <= rsp.value[`CSR_INDEX_W-1:0];
                `CSR_FIELD_END:   cfg.last_index   <= rsp.value[`CSR_INDEX_W-1:0];
                `CSR_FIELD_BASE:  cfg.base_address <= rsp.value;
                `CSR_FIELD_GRAN:  cfg.gran_shift   <= rsp.value[`CSR_GRAN_W-1:0];
                // Unknown codes leave the configuration as it was
                default: ;
            endcase
        end
    end

    // Granularity is the last word of a configuration
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            cfg_valid <= 1'b0;
        end else if (cfg_take) begin
            cfg_valid <= 1'b0;
        end else if (gran_write) begin
            cfg_valid <= 1'b1;
        end
    end

endmodule : csr_index_config

`default_nettype wire

/* verilog/csr_index_generator.sv */
// --------------------------------------
// CSR index generator
// One read request per index, up or down,
// address = base + (index << gran)
// --------------------------------------
`default_nettype none

`include "csr_index_settings.svh"

module csr_index_generator (
    input  logic                          ap_clk,
    input  logic                          areset_engine_csr_index,
    input  csr_index_pkg::csr_index_cfg_t cfg,
    input  logic [`CSR_TAG_W-1:0]         tag,
    input  logic                          gen_start,
    input  logic                          gen_pause,
    output logic                          gen_busy,
    output csr_index_pkg::req_packet_t    req
);

    logic                    busy;
    logic [`CSR_INDEX_W-1:0] cur_index;
    logic [`CSR_INDEX_W-1:0] last_index;
    logic                    count_up;
    logic [`CSR_ADDR_W-1:0]  base_address;
    logic [`CSR_GRAN_W-1:0]  gran_shift;
    logic [`CSR_TAG_W-1:0]   tag_q;
    logic                    emit;

    assign emit     = busy & ~gen_pause;
    assign gen_busy = busy;

    // Request leaves in the same cycle the index is stepped
    assign req.valid   = emit;
    assign req.tag     = tag_q;
    assign req.index   = cur_index;
    assign req.address = base_address +
        ({{(`CSR_ADDR_W - `CSR_INDEX_W){1'b0}}, cur_index} << gran_shift);

    // --------------------------------------
    // Job load and index stepping
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (gen_start) begin
            cur_index    <= cfg.first_index;
            last_index   <= cfg.last_index;
            count_up     <= cfg.direction;
            base_address <= cfg.base_address;
            gran_shift   <= cfg.gran_shift;
            tag_q        <= tag;
        end else if (emit && (cur_index != last_index)) begin
            cur_index <= count_up ? cur_index + 1'b1 : cur_index - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            busy <= 1'b0;
        end else if (gen_start) begin
            busy <= 1'b1;
        end else if (emit && (cur_index == last_index)) begin
            // Last index went out this cycle
            busy <= 1'b0;
        end
    end

endmodule : csr_index_generator

`default_nettype wire

/* verilog/csr_index_control.sv */
// --------------------------------------
// CSR index control FSM
// Sequences start, busy, pause and done
// for one job per descriptor
// --------------------------------------
`default_nettype none

module csr_index_control (
    input  logic ap_clk,
    input  logic areset_engine_csr_index,
    input  logic start_req,
    input  logic cfg_valid,
    input  logic gen_busy,
    input  logic req_fifo_empty,
    input  logic req_fifo_prog_full,
    output logic cfg_take,
    output logic gen_start,
    output logic gen_pause,
    output logic done
);

    csr_index_pkg::csr_index_state_t current_state;
    csr_index_pkg::csr_index_state_t next_state;

    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            current_state <= csr_index_pkg::CSR_INDEX_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    // --------------------------------------
    // Next state
    // --------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            csr_index_pkg::CSR_INDEX_RESET: begin
                next_state = csr_index_pkg::CSR_INDEX_IDLE;
            end
            csr_index_pkg::CSR_INDEX_IDLE: begin
                if (start_req && cfg_valid && !gen_busy) begin
                    next_state = csr_index_pkg::CSR_INDEX_START;
                end
            end
            csr_index_pkg::CSR_INDEX_START: begin
                next_state = csr_index_pkg::CSR_INDEX_BUSY;
            end
            csr_index_pkg::CSR_INDEX_BUSY: begin
                // Finished only once every request has drained
                if (!gen_busy && req_fifo_empty) begin
                    next_state = csr_index_pkg::CSR_INDEX_DONE;
                end else if (req_fifo_prog_full) begin
                    next_state = csr_index_pkg::CSR_INDEX_PAUSE;
                end
            end
            csr_index_pkg::CSR_INDEX_PAUSE: begin
                if (!req_fifo_prog_full) begin
                    next_state = csr_index_pkg::CSR_INDEX_BUSY;
                end
            end
            csr_index_pkg::CSR_INDEX_DONE: begin
                // Wait for the descriptor to be withdrawn
                if (!start_req) begin
                    next_state = csr_index_pkg::CSR_INDEX_IDLE;
                end
            end
            default: begin
                next_state = csr_index_pkg::CSR_INDEX_RESET;
            end
        endcase
    end

    // Outputs decoded straight from the state register
    assign gen_start = (current_state == csr_index_pkg::CSR_INDEX_START);
    assign cfg_take  = (current_state == csr_index_pkg::CSR_INDEX_START);
    assign gen_pause = (current_state == csr_index_pkg::CSR_INDEX_PAUSE);
    assign done      = (current_state == csr_index_pkg::CSR_INDEX_DONE);

endmodule : csr_index_control

`default_nettype wire

/* verilog/engine_csr_index.sv */
// --------------------------------------
// CSR index engine top level
// Registered boundary around the response
// FIFO, config, generator and request FIFO
// --------------------------------------
`default_nettype none

`include "csr_index_settings.svh"

module engine_csr_index (
    input  logic                       ap_clk,
    input  logic                       areset_engine_csr_index,
    input  csr_index_pkg::descriptor_t descriptor_in,
    input  csr_index_pkg::rsp_packet_t rsp_in,
    input  logic                       request_ready,
    output csr_index_pkg::req_packet_t request_out,
    output logic                       done_out
);

    localparam int RSP_W = `CSR_FIELD_W + `CSR_ADDR_W;
    localparam int REQ_W = $bits(csr_index_pkg::req_packet_t) - 1;

    csr_index_pkg::descriptor_t    descriptor_reg;
    csr_index_pkg::rsp_packet_t    rsp_in_reg;
    logic                          request_ready_reg;
    csr_index_pkg::rsp_packet_t    cfg_rsp;
    csr_index_pkg::csr_index_cfg_t cfg;
    csr_index_pkg::req_packet_t    gen_req;
    logic [RSP_W-1:0]              rsp_fifo_dout;
    logic [REQ_W-1:0]              req_fifo_dout;
    logic                          rsp_fifo_empty;
    logic                          rsp_pop;
    logic                          cfg_ready;
    logic                          cfg_valid;
    logic                          cfg_take;
    logic                          gen_start;
    logic                          gen_pause;
    logic                          gen_busy;
    logic                          req_push;
    logic                          req_pop;
    logic                          req_fifo_empty;
    logic                          req_fifo_full;
    logic                          req_fifo_prog_full;
    logic                          done_int;

    // --------------------------------------
    // Input registers
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            descriptor_reg.valid <= 1'b0;
            rsp_in_reg.valid     <= 1'b0;
            request_ready_reg    <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
            rsp_in_reg.valid     <= rsp_in.valid;
            request_ready_reg    <= request_ready;
        end
        descriptor_reg.tag <= descriptor_in.tag;
        rsp_in_reg.field   <= rsp_in.field;
        rsp_in_reg.value   <= rsp_in.value;
    end

    // --------------------------------------
    // Response path into the configuration
    // --------------------------------------
    assign rsp_pop = ~rsp_fifo_empty & cfg_ready;

    packet_fifo #(
        .WIDTH      (RSP_W),
        .DEPTH      (`RSP_FIFO_DEPTH),
        .PROG_THRESH(`FIFO_PROG_THRESH)
    ) i_rsp_fifo (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .din                    ({rsp_in_reg.field, rsp_in_reg.value}),
        .push                   (rsp_in_reg.valid),
        .pop                    (rsp_pop),
        .dout                   (rsp_fifo_dout),
        .empty                  (rsp_fifo_empty),
        .full                   (),
        .prog_full              ()
    );

    assign cfg_rsp.valid = rsp_pop;
    assign cfg_rsp.field = rsp_fifo_dout[RSP_W-1 -: `CSR_FIELD_W];
    assign cfg_rsp.value = rsp_fifo_dout[`CSR_ADDR_W-1:0];

    csr_index_config i_csr_index_config (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .rsp                    (cfg_rsp),
        .cfg_ready              (cfg_ready),
        .cfg_take               (cfg_take),
        .cfg                    (cfg),
        .cfg_valid              (cfg_valid)
    );

    // --------------------------------------
    // Generator and request FIFO
    // --------------------------------------
    csr_index_generator i_csr_index_generator (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .cfg                    (cfg),
        .tag                    (descriptor_reg.tag),
        .gen_start              (gen_start),
        .gen_pause              (gen_pause),
        .gen_busy               (gen_busy),
        .req                    (gen_req)
    );

    assign req_push = gen_req.valid;
    assign req_pop  = ~req_fifo_empty & request_ready_reg;

    packet_fifo #(
        .WIDTH      (REQ_W),
        .DEPTH      (`REQ_FIFO_DEPTH),
        .PROG_THRESH(`FIFO_PROG_THRESH)
    ) i_req_fifo (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .din                    ({gen_req.tag, gen_req.index, gen_req.address}),
        .push                   (req_push),
        .pop                    (req_pop),
        .dout                   (req_fifo_dout),
        .empty                  (req_fifo_empty),
        .full                   (req_fifo_full),
        .prog_full              (req_fifo_prog_full)
    );

    csr_index_control i_csr_index_control (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .start_req              (descriptor_reg.valid),
        .cfg_valid              (cfg_valid),
        .gen_busy               (gen_busy),
        .req_fifo_empty         (req_fifo_empty),
        .req_fifo_prog_full     (req_fifo_prog_full),
        .cfg_take               (cfg_take),
        .gen_start              (gen_start),
        .gen_pause              (gen_pause),
        .done                   (done_int)
    );

    // --------------------------------------
    // Output registers
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            request_out.valid <= 1'b0;
            done_out          <= 1'b0;
        end else begin
            request_out.valid <= req_pop;
            done_out          <= done_int;
        end
        request_out.tag     <= req_fifo_dout[REQ_W-1 -: `CSR_TAG_W];
        request_out.index   <= req_fifo_dout[`CSR_ADDR_W +: `CSR_INDEX_W];
        request_out.address <= req_fifo_dout[`CSR_ADDR_W-1:0];
    end

endmodule : engine_csr_index

`default_nettype wire

/* tests/engine_csr_index_asserts.sv */
// --------------------------------------
// CSR index engine assertions
// Reset values, done versus request
// and request FIFO overflow
// --------------------------------------
`default_nettype none

module engine_csr_index_asserts (
    input logic ap_clk,
    input logic areset_engine_csr_index,
    input logic request_valid,
    input logic done_out,
    input logic req_push,
    input logic req_fifo_full
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read back by the testbench at the end of the run
    int unsigned assert_fails;

    // Outputs are cleared by every reset edge
    reset_outputs_low: assert property (@(posedge ap_clk)
        areset_engine_csr_index |=> (!request_valid && !done_out))
        else begin
            assert_fails++;
            $error("request_out valid or done_out high after a reset edge");
        end

    done_without_request: assert property (@(posedge ap_clk)
        disable iff (areset_engine_csr_index)
        !(done_out && request_valid))
        else begin
            assert_fails++;
            $error("done_out and request_out valid high together");
        end

    no_push_when_full: assert property (@(posedge ap_clk)
        disable iff (areset_engine_csr_index)
        !(req_push && req_fifo_full))
        else begin
            assert_fails++;
            $error("request FIFO pushed while full");
        end

endmodule : engine_csr_index_asserts

bind engine_csr_index engine_csr_index_asserts i_asserts (
    .ap_clk                 (ap_clk),
    .areset_engine_csr_index(areset_engine_csr_index),
    .request_valid          (request_out.valid),
    .done_out               (done_out),
    .req_push               (req_push),
    .req_fifo_full          (req_fifo_full)
);

`default_nettype wire

/* tests/tb_engine_csr_index.sv */
// --------------------------------------
// CSR index engine testbench
// Table of jobs, reference model of the
// index sequence and request checks
// --------------------------------------
`default_nettype none

`include "csr_index_settings.svh"

module tb_engine_csr_index;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 6;
    localparam int WAIT_LIMIT = 2000;
    localparam int IW         = `CSR_INDEX_W;
    localparam int AW         = `CSR_ADDR_W;

    // Mask bits 0..3 select the dir, start, end and base words
    typedef struct packed {
        logic                   direction;
        logic [IW-1:0]          first_index;
        logic [IW-1:0]          last_index;
        logic [AW-1:0]          base_address;
        logic [`CSR_GRAN_W-1:0] gran_shift;
        logic [`CSR_TAG_W-1:0]  tag;
        logic                   back_pressure;
        logic [3:0]             word_mask;
    } job_row_t;

    job_row_t rows [NUM_ROWS] = '{
        '{1'b1, 32'd10,  32'd20,  64'h0000_0000_8000_0000, 5'd3, 8'h11, 1'b0, 4'b1111},
        '{1'b0, 32'd40,  32'd31,  64'h0000_0001_0000_0000, 5'd6, 8'h22, 1'b0, 4'b1111},
        '{1'b1, 32'd7,   32'd7,   64'h0000_0000_0000_4000, 5'd2, 8'h33, 1'b0, 4'b1111},
        '{1'b1, 32'd100, 32'd139, 64'h0000_0000_0002_0000, 5'd4, 8'h44, 1'b1, 4'b1111},
        // Only the last index and granularity change here
        '{1'b0, 32'd0,   32'd120, 64'h0,                   5'd7, 8'h55, 1'b1, 4'b0100},
        '{1'b0, 32'd300, 32'd260, 64'h0000_0000_FFFF_0000, 5'd0, 8'h66, 1'b1, 4'b1111}
    };

    logic                          ap_clk;
    logic                          areset_engine_csr_index;
    csr_index_pkg::descriptor_t    descriptor_in;
    csr_index_pkg::rsp_packet_t    rsp_in;
    logic                          request_ready;
    csr_index_pkg::req_packet_t    request_out;
    logic                          done_out;

    csr_index_pkg::csr_index_cfg_t model_cfg;
    csr_index_pkg::req_packet_t    exp_q [$];
    csr_index_pkg::req_packet_t    got_q [$];
    logic [31:0]                   lcg_state;
    int                            errors;
    int                            rows_run;
    logic                          timed_out;

    engine_csr_index i_dut (
        .ap_clk                 (ap_clk),
        .areset_engine_csr_index(areset_engine_csr_index),
        .descriptor_in          (descriptor_in),
        .rsp_in                 (rsp_in),
        .request_ready          (request_ready),
        .request_out            (request_out),
        .done_out               (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------
    // Compare tasks
    // --------------------------------------
    task automatic check_request(input string name, input csr_index_pkg::req_packet_t got,
                                 input csr_index_pkg::req_packet_t exp);
        string got_s;
        string exp_s;
        if (got !== exp) begin
            errors++;
            got_s = $sformatf("tag=%h index=%h address=%h", got.tag, got.index, got.address);
            exp_s = $sformatf("tag=%h index=%h address=%h", exp.tag, exp.index, exp.address);
            $display("Fail at %0t: %s got %s, expected %s", $time, name, got_s, exp_s);
        end
    endtask

    task automatic check_count(input string name, input logic [IW-1:0] got,
                               input logic [IW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // --------------------------------------
    // Stimulus
    // --------------------------------------
    task automatic send_word(input logic [`CSR_FIELD_W-1:0] code, input logic [AW-1:0] value);
        @(posedge ap_clk);
        #1;
        rsp_in.valid = 1'b1;
        rsp_in.field = code;
        rsp_in.value = value;
    endtask

    // Model follows every word that is written
    task automatic send_config(input job_row_t row);
        if (row.word_mask[0]) begin
            send_word(`CSR_FIELD_DIR, AW'(row.direction));
            model_cfg.direction = row.direction;
        end
        if (row.word_mask[1]) begin
            send_word(`CSR_FIELD_START, AW'(row.first_index));
            model_cfg.first_index = row.first_index;
        end
        if (row.word_mask[2]) begin
            send_word(`CSR_FIELD_END, AW'(row.last_index));
            model_cfg.last_index = row.last_index;
        end
        if (row.word_mask[3]) begin
            send_word(`CSR_FIELD_BASE, row.base_address);
            model_cfg.base_address = row.base_address;
        end
        send_word(`CSR_FIELD_GRAN, AW'(row.gran_shift));
        model_cfg.gran_shift = row.gran_shift;
        @(posedge ap_clk);
        #1;
        rsp_in.valid = 1'b0;
    endtask

    // Every index from first to last inclusive, address = base + (index << gran)
    task automatic build_expected(input logic [`CSR_TAG_W-1:0] tag);
        logic [IW-1:0]              span;
        logic [IW-1:0]              idx;
        csr_index_pkg::req_packet_t p;
        exp_q.delete();
        span = model_cfg.direction ? model_cfg.last_index - model_cfg.first_index
                                   : model_cfg.first_index - model_cfg.last_index;
        for (longint k = 0; k <= longint'(span); k++) begin
            idx = model_cfg.direction ? model_cfg.first_index + IW'(k)
                                      : model_cfg.first_index - IW'(k);
            p.valid   = 1'b1;
            p.tag     = tag;
            p.index   = idx;
            p.address = model_cfg.base_address + (AW'(idx) << model_cfg.gran_shift);
            exp_q.push_back(p);
        end
    endtask

    task automatic collect_requests(input int row, input logic back_pressure);
        int   cycles;
        logic seen_done;
        cycles    = 0;
        seen_done = 1'b0;
        got_q.delete();
        while (!seen_done && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            #1;
            if (request_out.valid) begin
                got_q.push_back(request_out);
            end
            seen_done = done_out;
            if (back_pressure) begin
                lcg_state     = lcg_next(lcg_state);
                request_ready = lcg_state[31];
            end
            cycles++;
        end
        if (!seen_done) begin
            $display("Timeout on row %0d: done_out never rose in %0d cycles", row, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // done_out must fall once the descriptor goes away
    task automatic withdraw_descriptor(input int row);
        int   cycles;
        logic still_done;
        cycles        = 0;
        still_done    = 1'b1;
        descriptor_in.valid = 1'b0;
        request_ready = 1'b1;
        while (still_done && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            #1;
            if (request_out.valid) begin
                errors++;
                $display("Extra request after done_out on row %0d at %0t", row, $time);
            end
            still_done = done_out;
            cycles++;
        end
        if (still_done) begin
            $display("Timeout on row %0d: done_out stayed high after withdrawal", row);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_row(input int r);
        int errors_before;
        errors_before = errors;
        send_config(rows[r]);
        build_expected(rows[r].tag);
        @(posedge ap_clk);
        #1;
        descriptor_in.valid = 1'b1;
        descriptor_in.tag   = rows[r].tag;
        collect_requests(r, rows[r].back_pressure);
        if (!timed_out) begin
            check_count("request count", IW'(got_q.size()), IW'(exp_q.size()));
            for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
                check_request($sformatf("request_out[%0d]", i), got_q[i], exp_q[i]);
            end
            withdraw_descriptor(r);
        end
        rows_run++;
        $display("Row %0d: %0d of %0d requests, %0d errors", r, got_q.size(), exp_q.size(),
                 errors - errors_before);
    endtask

    // --------------------------------------
    // Main sequence
    // --------------------------------------
    initial begin
        int total_errors;
        $timeformat(-9, 0, " ns", 0);
        areset_engine_csr_index = 1'b1;
        descriptor_in = '0;
        rsp_in        = '0;
        request_ready = 1'b0;
        model_cfg     = '0;
        lcg_state     = 32'h67689f0e;
        errors        = 0;
        rows_run      = 0;
        timed_out     = 1'b0;

        repeat (16) @(posedge ap_clk);
        #1;
        areset_engine_csr_index = 1'b0;
        request_ready = 1'b1;
        check_flag("done_out", done_out, 1'b0);
        check_flag("request_out.valid", request_out.valid, 1'b0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!timed_out) begin
                run_row(r);
            end
        end

        total_errors = errors + int'(i_dut.i_asserts.assert_fails);
        $display("Rows run: %0d of %0d, failed checks: %0d", rows_run, NUM_ROWS, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_engine_csr_index

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/csr_index_pkg.sv
verilog/packet_fifo.sv
verilog/csr_index_config.sv
verilog/csr_index_generator.sv
verilog/csr_index_control.sv
verilog/engine_csr_index.sv
tests/engine_csr_index_asserts.sv
tests/tb_engine_csr_index.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_engine_csr_index
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
